// File: hw/bd_pkg.sv
package bd_pkg;

  // node ids are three bits wide, which caps the chain at eight routers
  localparam int NODE_BITS = 3;
  localparam int SEQ_BITS  = 4;

  // a flit is one link beat, and last closes the wormhole behind it
  typedef struct packed {
    logic       last;
    logic [9:0] payload;
  } flit_t;

  // forward half of a link; the credit bit runs back on its own wire
  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

  typedef enum logic [1:0] {
    PORT_TOP   = 2'd0,
    PORT_BOT   = 2'd1,
    PORT_LOCAL = 2'd2
  } port_e;

  typedef enum logic {
    WORM_IDLE = 1'b0,
    WORM_BUSY = 1'b1
  } worm_e;

  // head payload is {dest[2:0], src[2:0], seq[3:0]}
  function automatic logic [NODE_BITS-1:0] head_dest(flit_t f);
    return f.payload[9:7];
  endfunction

  function automatic logic [NODE_BITS-1:0] head_src(flit_t f);
    return f.payload[6:4];
  endfunction

  function automatic logic [SEQ_BITS-1:0] head_seq(flit_t f);
    return f.payload[3:0];
  endfunction

  function automatic flit_t make_head(logic [NODE_BITS-1:0] dest, logic [NODE_BITS-1:0] src,
                                      logic [SEQ_BITS-1:0] seq, logic last);
    flit_t f;
    f.last    = last;
    f.payload = {dest, src, seq};
    return f;
  endfunction

endpackage

// File: hw/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo import bd_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic  BD_in_clk,
  input  logic  rst_n,
  input  link_t wr_link,
  input  logic  pop,
  output flit_t head,
  output logic  not_empty,
  output logic  credit
);

  localparam int PW = $clog2(FIFO_DEPTH);
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  flit_t         mem [FIFO_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;

  // depth is a power of two, so the pointers simply wrap
  always_ff @(posedge BD_in_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (wr_link.valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count  <= count + CW'(wr_link.valid) - CW'(pop);
      // one credit goes back upstream for every slot freed
      credit <= pop;
    end
  end

  always_ff @(posedge BD_in_clk) begin
    if (wr_link.valid) begin
      mem[wr_ptr] <= wr_link.flit;
    end
  end

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);

  // a write into a full buffer means the upstream sender overdrew its credits
  a_no_overflow: assert property (@(posedge BD_in_clk) disable iff (!rst_n)
    !(wr_link.valid && (count == CW'(FIFO_DEPTH))));

  // the output arbiter must never take a flit that is not there
  a_no_underflow: assert property (@(posedge BD_in_clk) disable iff (!rst_n)
    !(pop && (count == '0)));

endmodule

// File: hw/router_input.sv
`timescale 1ns/1ps

module router_input import bd_pkg::*; #(
  parameter int NODE_ID    = 0,
  parameter int NUM_NODES  = 2,
  parameter int FIFO_DEPTH = 4
) (
  input  logic  BD_in_clk,
  input  logic  rst_n,
  input  link_t in_link,
  input  logic  pop,
  output logic  credit,
  output flit_t head,
  output logic  req,
  output port_e req_port
);

  localparam logic [NODE_BITS-1:0] MY_ID = NODE_BITS'(NODE_ID);

  logic  not_empty;
  port_e route;
  port_e hold_port;
  worm_e state;

  flit_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .BD_in_clk (BD_in_clk),
    .rst_n     (rst_n),
    .wr_link   (in_link),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .credit    (credit)
  );

  // dimension order along the chain: lower ids sit toward top
  always_comb begin
    if (head_dest(head) == MY_ID) begin
      route = PORT_LOCAL;
    end else if (head_dest(head) < MY_ID) begin
      route = PORT_TOP;
    end else begin
      route = PORT_BOT;
    end
  end

  // body flits carry no address, so they follow the port latched at the head
  assign req_port = (state == WORM_BUSY) ? hold_port : route;
  assign req      = not_empty;

  always_ff @(posedge BD_in_clk) begin
    if (!rst_n) begin
      state     <= WORM_IDLE;
      hold_port <= PORT_LOCAL;
    end else if (pop) begin
      if (head.last) begin
        state <= WORM_IDLE;
      end else begin
        state <= WORM_BUSY;
        if (state == WORM_IDLE) begin
          hold_port <= route;
        end
      end
    end
  end

  // the end ports of the chain are tied off, which is only safe
  // while every head addresses a node that exists
  a_dest_in_chain: assert property (@(posedge BD_in_clk) disable iff (!rst_n)
    (not_empty && (state == WORM_IDLE)) |-> (int'(head_dest(head)) < NUM_NODES));

endmodule

// File: hw/output_port.sv
`timescale 1ns/1ps

module output_port import bd_pkg::*; #(
  parameter int    FIFO_DEPTH = 4,
  parameter port_e OUT_PORT   = PORT_LOCAL
) (
  input  logic            BD_in_clk,
  input  logic            rst_n,
  input  logic     [2:0]  req,
  input  port_e    [2:0]  req_port,
  input  flit_t    [2:0]  head,
  input  logic            credit_in,
  output logic     [2:0]  pop,
  output link_t           out_link
);

  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic  [2:0]    cand;
  logic  [CW-1:0] credits;
  worm_e          state;
  port_e          owner;
  port_e          last_win;
  port_e          pick;
  logic           pick_ok;
  port_e          sel;
  logic           sel_ok;
  logic           send;
  logic           out_valid_q;
  flit_t          out_flit_q;

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      cand[i] = req[i] && (req_port[i] == OUT_PORT);
    end
  end

  // round robin: the input right after the last winner has top priority,
  // so the loop runs backward and the nearest candidate overwrites the rest
  always_comb begin : arb
    int j;
    pick    = last_win;
    pick_ok = 1'b0;
    for (int k = 3; k >= 1; k--) begin
      j = (int'(last_win) + k) % 3;
      if (cand[j]) begin
        pick    = port_e'(j[1:0]);
        pick_ok = 1'b1;
      end
    end
  end

  // a locked worm ignores everyone except its owner
  assign sel    = (state == WORM_BUSY) ? owner : pick;
  assign sel_ok = (state == WORM_BUSY) ? cand[owner] : pick_ok;
  assign send   = sel_ok && (credits != '0);
  assign pop    = send ? (3'b001 << sel) : 3'b000;

  always_ff @(posedge BD_in_clk) begin
    if (!rst_n) begin
      state       <= WORM_IDLE;
      owner       <= PORT_TOP;
      last_win    <= PORT_LOCAL;
      credits     <= CW'(FIFO_DEPTH);
      out_valid_q <= 1'b0;
    end else begin
      credits     <= credits - CW'(send) + CW'(credit_in);
      out_valid_q <= send;
      if (send) begin
        if (state == WORM_IDLE) begin
          last_win <= sel;
          owner    <= sel;
        end
        state <= head[sel].last ? WORM_IDLE : WORM_BUSY;
      end
    end
  end

  always_ff @(posedge BD_in_clk) begin
    if (send) begin
      out_flit_q <= head[sel];
    end
  end

  assign out_link = '{valid: out_valid_q, flit: out_flit_q};

  // more credits than buffer slots means the far side returned one too many
  a_credit_bound: assert property (@(posedge BD_in_clk) disable iff (!rst_n)
    credits <= CW'(FIFO_DEPTH));

endmodule

// File: hw/bd_router.sv
`timescale 1ns/1ps

module bd_router import bd_pkg::*; #(
  parameter int NODE_ID    = 0,
  parameter int NUM_NODES  = 2,
  parameter int FIFO_DEPTH = 4
) (
  input  logic  BD_in_clk,
  input  logic  rst_n,
  input  link_t top_in,
  input  link_t bot_in,
  input  link_t local_in,
  input  logic  top_credit_in,
  input  logic  bot_credit_in,
  input  logic  local_credit_in,
  output link_t top_out,
  output link_t bot_out,
  output link_t local_out,
  output logic  top_credit_out,
  output logic  bot_credit_out,
  output logic  local_credit_out
);

  // every vector below is indexed by port_e
  link_t [2:0]      in_l;
  link_t [2:0]      out_l;
  logic  [2:0]      cr_in;
  logic  [2:0]      cr_out;
  flit_t [2:0]      head;
  logic  [2:0]      req;
  port_e [2:0]      req_port;
  logic  [2:0]      in_pop;
  logic  [2:0][2:0] pop_m;

  assign in_l[PORT_TOP]    = top_in;
  assign in_l[PORT_BOT]    = bot_in;
  assign in_l[PORT_LOCAL]  = local_in;
  assign cr_in[PORT_TOP]   = top_credit_in;
  assign cr_in[PORT_BOT]   = bot_credit_in;
  assign cr_in[PORT_LOCAL] = local_credit_in;

  assign top_out          = out_l[PORT_TOP];
  assign bot_out          = out_l[PORT_BOT];
  assign local_out        = out_l[PORT_LOCAL];
  assign top_credit_out   = cr_out[PORT_TOP];
  assign bot_credit_out   = cr_out[PORT_BOT];
  assign local_credit_out = cr_out[PORT_LOCAL];

  // at most one output pops a given input, since each input asks for one port
  always_comb begin
    in_pop = '0;
    for (int o = 0; o < 3; o++) begin
      in_pop |= pop_m[o];
    end
  end

  for (genvar g = 0; g < 3; g++) begin : g_port
    router_input #(
      .NODE_ID    (NODE_ID),
      .NUM_NODES  (NUM_NODES),
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_in (
      .BD_in_clk (BD_in_clk),
      .rst_n     (rst_n),
      .in_link   (in_l[g]),
      .pop       (in_pop[g]),
      .credit    (cr_out[g]),
      .head      (head[g]),
      .req       (req[g]),
      .req_port  (req_port[g])
    );

    output_port #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .OUT_PORT   (port_e'(g))
    ) u_out (
      .BD_in_clk (BD_in_clk),
      .rst_n     (rst_n),
      .req       (req),
      .req_port  (req_port),
      .head      (head),
      .credit_in (cr_in[g]),
      .pop       (pop_m[g]),
      .out_link  (out_l[g])
    );
  end

endmodule

// File: hw/bd_chain_top.sv
`timescale 1ns/1ps

module bd_chain_top import bd_pkg::*; #(
  parameter int NUM_NODES  = 2,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  BD_in_clk,
  input  logic                  rst_n,
  input  link_t [NUM_NODES-1:0] inj,
  input  logic  [NUM_NODES-1:0] ej_credit,
  output logic  [NUM_NODES-1:0] inj_credit,
  output link_t [NUM_NODES-1:0] ej
);

  // dn_link[k] feeds the top input of node k, dn_cr[k] is that input's credit
  // up_link[k] is the top output of node k, which feeds the bot input of node k-1
  // up_cr[k] carries credits from the bot input of node k-1 up to node k
  link_t [NUM_NODES:0] dn_link;
  logic  [NUM_NODES:0] dn_cr;
  link_t [NUM_NODES:0] up_link;
  logic  [NUM_NODES:0] up_cr;

  // chain ends see an idle link that never grants a credit
  assign dn_link[0]         = '0;
  assign up_cr[0]           = 1'b0;
  assign up_link[NUM_NODES] = '0;
  assign dn_cr[NUM_NODES]   = 1'b0;

  for (genvar n = 0; n < NUM_NODES; n++) begin : g_node
    bd_router #(
      .NODE_ID    (n),
      .NUM_NODES  (NUM_NODES),
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_router (
      .BD_in_clk        (BD_in_clk),
      .rst_n            (rst_n),
      .top_in           (dn_link[n]),
      .bot_in           (up_link[n+1]),
      .local_in         (inj[n]),
      .top_credit_in    (up_cr[n]),
      .bot_credit_in    (dn_cr[n+1]),
      .local_credit_in  (ej_credit[n]),
      .top_out          (up_link[n]),
      .bot_out          (dn_link[n+1]),
      .local_out        (ej[n]),
      .top_credit_out   (dn_cr[n]),
      .bot_credit_out   (up_cr[n+1]),
      .local_credit_out (inj_credit[n])
    );
  end

endmodule

// File: test/bd_chain_model.svh
`ifndef BD_CHAIN_MODEL_SVH
`define BD_CHAIN_MODEL_SVH

// expected flits and head seq values per source and destination, oldest first
flit_t exp_q[NUM_NODES][NUM_NODES][$];
int    seq_q[NUM_NODES][NUM_NODES][$];
logic  rx_busy[NUM_NODES];
int    rx_src[NUM_NODES];

task automatic check_value(input string name, input int exp_v, input int act_v);
  checks++;
  assert (exp_v == act_v) else begin
    errors++;
    $display("FAIL %s expected %0h actual %0h", name, exp_v, act_v);
  end
endtask

task automatic check_true(input logic ok, input string what);
  checks++;
  assert (ok) else begin
    errors++;
    $display("ERROR %s", what);
  end
endtask

task automatic model_reset();
  for (int n = 0; n < NUM_NODES; n++) begin
    rx_busy[n] = 1'b0;
    rx_src[n]  = 0;
  end
endtask

task automatic expect_flit(input int src, input int dest, input flit_t f);
  exp_q[src][dest].push_back(f);
endtask

task automatic expect_seq(input int src, input int dest, input int seq);
  seq_q[src][dest].push_back(seq);
endtask

// a flit that arrives mid packet must belong to the packet whose head came last
task automatic eject_flit(input int node, input flit_t f);
  flit_t exp_f;
  int    src;
  int    seq_full;
  if (!rx_busy[node]) begin
    check_value("delivery_dest", node, int'(f.payload[9:7]));
    rx_src[node] = int'(f.payload[6:4]);
    src = rx_src[node];
    if (src < NUM_NODES && seq_q[src][node].size() > 0) begin
      seq_full = seq_q[src][node].pop_front();
      check_value("seq_order", seq_full % 16, int'(f.payload[3:0]));
    end
  end
  src = rx_src[node];
  check_true(src < NUM_NODES && exp_q[src][node].size() > 0,
             $sformatf("node %0d ejected a flit that no packet from source %0d accounts for",
                       node, src));
  if (src < NUM_NODES && exp_q[src][node].size() > 0) begin
    exp_f = exp_q[src][node].pop_front();
    check_value("packet_flit", int'(exp_f), int'(f));
  end
  rx_busy[node] = !f.last;
endtask

function automatic int model_pending();
  int total;
  total = 0;
  for (int s = 0; s < NUM_NODES; s++) begin
    for (int d = 0; d < NUM_NODES; d++) begin
      total += exp_q[s][d].size();
    end
  end
  return total;
endfunction

`endif

// File: test/bd_chain_tb.sv
`timescale 1ns/1ps

module bd_chain_tb import bd_pkg::*; ();

  localparam int NUM_NODES    = 2;
  localparam int FIFO_DEPTH   = 4;
  localparam int PKTS         = 40;
  localparam int MAX_LEN      = 5;
  localparam int RESET_CYCLES = 10;
  localparam int STALL_START  = 100;
  localparam int STALL_LEN    = 50;
  localparam int SEED         = 7;
  // each packet gets a budget of six flit slots at forty cycles apiece
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + STALL_LEN + NUM_NODES * PKTS * 6 * 40;

  logic                  BD_in_clk = 1'b0;
  logic                  rst_n;
  link_t [NUM_NODES-1:0] inj;
  logic  [NUM_NODES-1:0] ej_credit;
  logic  [NUM_NODES-1:0] inj_credit;
  link_t [NUM_NODES-1:0] ej;

  int    errors;
  int    checks;
  int    cycle;
  logic  stall;
  int    inj_total;
  int    ej_total;
  int    inj_cr[NUM_NODES];
  int    inj_ret[NUM_NODES];
  int    inj_sent[NUM_NODES];
  int    ej_cnt[NUM_NODES];
  int    ej_ret[NUM_NODES];
  int    seq_cnt[NUM_NODES];
  int    body_cnt[NUM_NODES];
  int    pkts_built[NUM_NODES];
  flit_t tx_q[NUM_NODES][$];
  int    due_q[NUM_NODES][$];

  `include "bd_chain_model.svh"

  bd_chain_top #(
    .NUM_NODES  (NUM_NODES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) UUT (
    .BD_in_clk  (BD_in_clk),
    .rst_n      (rst_n),
    .inj        (inj),
    .ej_credit  (ej_credit),
    .inj_credit (inj_credit),
    .ej         (ej)
  );

  always #20 BD_in_clk = ~BD_in_clk;

  // head payload is {dest, src, seq}, bodies carry a running count per node
  task automatic build_packet(input int n);
    flit_t f;
    int    dest;
    int    len;
    dest      = $urandom % NUM_NODES;
    len       = 1 + $urandom % MAX_LEN;
    f.last    = (len == 1);
    f.payload = {3'(dest), 3'(n), 4'(seq_cnt[n])};
    tx_q[n].push_back(f);
    expect_flit(n, dest, f);
    expect_seq(n, dest, seq_cnt[n]);
    for (int i = 1; i < len; i++) begin
      f.last    = (i == len - 1);
      f.payload = 10'(body_cnt[n]);
      body_cnt[n]++;
      tx_q[n].push_back(f);
      expect_flit(n, dest, f);
    end
    seq_cnt[n]++;
    pkts_built[n]++;
  endtask

  task automatic step_node(input int n);
    flit_t f;
    if (inj_credit[n]) begin
      inj_cr[n]++;
      inj_ret[n]++;
      check_true(inj_ret[n] <= inj_sent[n],
                 $sformatf("node %0d returned more inject credits than flits injected", n));
    end
    if (ej[n].valid) begin
      eject_flit(n, ej[n].flit);
      ej_cnt[n]++;
      ej_total++;
      due_q[n].push_back(cycle + int'($urandom % 4));
      // the router may only have as many flits in flight as we gave it credits
      check_true(ej_cnt[n] - ej_ret[n] <= FIFO_DEPTH,
                 $sformatf("node %0d ejected a flit without an eject credit", n));
    end
    if (!stall && due_q[n].size() > 0 && due_q[n][0] <= cycle) begin
      ej_credit[n] = 1'b1;
      void'(due_q[n].pop_front());
      ej_ret[n]++;
    end else begin
      ej_credit[n] = 1'b0;
    end
    if (tx_q[n].size() == 0 && pkts_built[n] < PKTS) begin
      build_packet(n);
    end
    if (tx_q[n].size() > 0 && inj_cr[n] > 0 && ($urandom % 4) != 0) begin
      f = tx_q[n].pop_front();
      inj[n].valid = 1'b1;
      inj[n].flit  = f;
      inj_cr[n]--;
      inj_sent[n]++;
      inj_total++;
    end else begin
      inj[n] = '0;
    end
  endtask

  task automatic run_cycle();
    @(negedge BD_in_clk);
    cycle++;
    stall = (cycle >= STALL_START) && (cycle < STALL_START + STALL_LEN);
    for (int n = 0; n < NUM_NODES; n++) begin
      step_node(n);
    end
  endtask

  function automatic logic traffic_done();
    logic done;
    done = (ej_total == inj_total);
    for (int n = 0; n < NUM_NODES; n++) begin
      if (pkts_built[n] < PKTS || tx_q[n].size() > 0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  initial begin
    rst_n     = 1'b0;
    inj       = '0;
    ej_credit = '0;
    stall     = 1'b0;
    cycle     = 0;
    void'($urandom(SEED));
    model_reset();
    for (int n = 0; n < NUM_NODES; n++) begin
      inj_cr[n] = FIFO_DEPTH;
    end
    repeat (RESET_CYCLES) @(negedge BD_in_clk);
    rst_n = 1'b1;
    while (!traffic_done()) begin
      run_cycle();
    end
    // let the last credits travel back before counting them
    repeat (8) run_cycle();
    for (int n = 0; n < NUM_NODES; n++) begin
      check_value("inj_credit_final", FIFO_DEPTH, inj_cr[n]);
    end
    check_value("model_empty", 0, model_pending());
    check_value("flit_count", inj_total, ej_total);
    $display("checks %0d errors %0d flits injected %0d ejected %0d",
             checks, errors, inj_total, ej_total);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge BD_in_clk);
    $display("watchdog expired after %0d cycles with %0d of %0d flits ejected",
             WATCHDOG_CYCLES, ej_total, inj_total);
    $display("checks %0d errors %0d", checks, errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: build.f
+incdir+test
hw/bd_pkg.sv
hw/flit_fifo.sv
hw/router_input.sv
hw/output_port.sv
hw/bd_router.sv
hw/bd_chain_top.sv
test/bd_chain_tb.sv

// File: Makefile
# Verilator build and run of the router chain testbench

VERILATOR ?= verilator
TOP       ?= bd_chain_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
